//--- dv/tb_pod_row.sv
module tb_pod_row
  import noc_pkg::*;
  import mc_pkg::*;
();

  localparam int num_tiles_lp = 4;
  localparam int words_lp = 1 << addr_width_gp;
  // more than every buffer in the row can hold
  localparam int burst_lp = 40;
  localparam int rand_reqs_lp = 300;
  localparam int total_reqs_lp = 2 + 2 * num_tiles_lp + burst_lp + 5 + rand_reqs_lp;

  logic clk_i;
  logic rst_i;
  logic req_v_i;
  logic req_ready_o;
  mc_op_e req_op_i;
  logic [x_cord_width_gp-1:0] req_x_i;
  logic [addr_width_gp-1:0] req_addr_i;
  logic [data_width_gp-1:0] req_data_i;
  logic resp_v_o;
  logic resp_ready_i;
  logic [x_cord_width_gp-1:0] resp_x_o;
  mc_op_e resp_op_o;
  logic [addr_width_gp-1:0] resp_addr_o;
  logic [data_width_gp-1:0] resp_data_o;

  // reference model with one scratchpad and one response queue per tile
  logic [data_width_gp-1:0] model_mem [num_tiles_lp+1][words_lp];
  bit written [num_tiles_lp+1][words_lp];
  logic [addr_width_gp+data_width_gp-1:0] exp_q [num_tiles_lp+1][$];
  logic [addr_width_gp+data_width_gp-1:0] exp_word;
  int seed;
  int errors;
  int test_errors;
  int tests_passed;
  int tests_failed;
  int resp_tile;
  bit any_accepted;
  bit rand_ready;
  string test_name;

  pod_row #(
    .num_tiles_x_p(num_tiles_lp)
  ) pod_row_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    repeat (total_reqs_lp * 50 + 1000) @(posedge clk_i);
    $display("watchdog expired, the run did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  a_idle_after_reset: assert property (@(posedge clk_i) disable iff (rst_i)
    !any_accepted |-> !resp_v_o)
    else begin
      errors++;
      $display("a response appeared before any request was accepted");
    end

  a_resp_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (resp_v_o && !resp_ready_i) |=> (resp_v_o && $stable(resp_x_o) && $stable(resp_op_o)
      && $stable(resp_addr_o) && $stable(resp_data_o)))
    else begin
      errors++;
      $display("a stalled response was dropped or changed in test %s", test_name);
    end

  a_bad_x_refused: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_v_i && (req_x_i == '0 || req_x_i > num_tiles_lp)) |-> !req_ready_o)
    else begin
      errors++;
      $display("a request to tile %0d outside the row was accepted", req_x_i);
    end

  always @(posedge clk_i) begin
    if (!rst_i && resp_v_o && resp_ready_i) begin
      resp_tile = int'(resp_x_o);
      if (resp_tile < 1 || resp_tile > num_tiles_lp || exp_q[resp_tile].size() == 0) begin
        errors++;
        $display("unexpected response from tile %0d in test %s", resp_tile, test_name);
      end else begin
        exp_word = exp_q[resp_tile].pop_front();
        a_resp_match: assert (resp_op_o == op_resp && {resp_addr_o, resp_data_o} == exp_word)
          else begin
            errors++;
            $display("Error: %s tile %0d expected op_resp addr %0d %h, actual %s addr %0d %h",
                     test_name, resp_tile,
                     exp_word[addr_width_gp+data_width_gp-1:data_width_gp],
                     exp_word[data_width_gp-1:0],
                     resp_op_o.name(), resp_addr_o, resp_data_o);
          end
      end
    end
  end

  // one falling edge with an optional random host ready
  task automatic step();
    int r;
    @(negedge clk_i);
    if (rand_ready) begin
      r = $random(seed);
      resp_ready_i = r[0];
    end
  endtask

  task automatic record_req(input mc_op_e op, input int x, input int addr,
                            input logic [data_width_gp-1:0] data);
    any_accepted = 1'b1;
    if (x >= 1 && x <= num_tiles_lp) begin
      if (op == op_store) begin
        model_mem[x][addr] = data;
        written[x][addr] = 1'b1;
      end
      exp_q[x].push_back({addr_width_gp'(addr), model_mem[x][addr]});
    end
  endtask

  // called and returns just after a falling edge
  task automatic issue(input mc_op_e op, input int x, input int addr,
                       input logic [data_width_gp-1:0] data, input int limit, output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    req_v_i = 1'b1;
    req_op_i = op;
    req_x_i = x_cord_width_gp'(x);
    req_addr_i = addr_width_gp'(addr);
    req_data_i = data;
    while (!ok && n < limit) begin
      @(posedge clk_i);
      if (req_ready_o) begin
        ok = 1'b1;
        record_req(op, x, addr, data);
      end
      step();
      n++;
    end
    req_v_i = 1'b0;
  endtask

  task automatic send(input mc_op_e op, input int x, input int addr,
                      input logic [data_width_gp-1:0] data);
    bit ok;
    issue(op, x, addr, data, 1000, ok);
    if (!ok) begin
      errors++;
      $display("request to tile %0d was never accepted in test %s", x, test_name);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = errors;
  endtask

  // waits for every expected response and then reports
  task automatic end_test();
    int pending;
    do begin
      pending = 0;
      for (int t = 1; t <= num_tiles_lp; t++) begin
        pending += exp_q[t].size();
      end
      step();
    end while (pending != 0);
    repeat (5) step();
    if (errors == test_errors) begin
      tests_passed++;
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - test_errors);
    end
  endtask

  initial begin
    bit ok;
    bit saw_stall;
    int r;
    int x;
    int addr;
    mc_op_e op;
    seed = 32'h42b1_2ef3;
    rst_i = 1'b1;
    req_v_i = 1'b0;
    req_op_i = op_store;
    req_x_i = '0;
    req_addr_i = '0;
    req_data_i = '0;
    resp_ready_i = 1'b1;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    start_test("idle_after_reset");
    repeat (20) step();
    end_test();

    start_test("store_then_load");
    send(op_store, 2, 9, 32'hdead_beef);
    send(op_load, 2, 9, '0);
    end_test();

    start_test("per_tile_scratchpad");
    for (int t = 1; t <= num_tiles_lp; t++) begin
      send(op_store, t, 5, 32'hc0de_0000 + t);
    end
    for (int t = 1; t <= num_tiles_lp; t++) begin
      send(op_load, t, 5, '0);
    end
    end_test();

    start_test("back_pressure");
    resp_ready_i = 1'b0;
    saw_stall = 1'b0;
    for (int i = 0; i < burst_lp && !saw_stall; i++) begin
      issue(op_store, 1 + i % num_tiles_lp, 20 + i, 32'h5a00_0000 + i, 8, ok);
      saw_stall = !ok;
    end
    a_stall_seen: assert (saw_stall)
      else begin
        errors++;
        $display("req_ready_o never dropped while responses were held");
      end
    resp_ready_i = 1'b1;
    end_test();

    start_test("bad_coordinate");
    issue(op_store, 0, 3, 32'h1111_1111, 20, ok);
    issue(op_load, num_tiles_lp + 1, 3, '0, 20, ok);
    issue(op_store, 15, 3, 32'h3333_3333, 20, ok);
    send(op_store, num_tiles_lp, 3, 32'h2222_2222);
    send(op_load, num_tiles_lp, 3, '0);
    end_test();

    start_test("random_traffic");
    rand_ready = 1'b1;
    for (int i = 0; i < rand_reqs_lp; i++) begin
      r = $random(seed);
      x = 1 + int'(r[15:8]) % num_tiles_lp;
      addr = int'(r[21:16]);
      // loads only where the model holds a word
      op = (r[0] && written[x][addr]) ? op_load : op_store;
      send(op, x, addr, $random(seed));
    end
    rand_ready = 1'b0;
    resp_ready_i = 1'b1;
    end_test();

    $display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
src/noc_pkg.sv
src/mc_pkg.sv
src/mesh_router.sv
src/tile_endpoint.sv
src/host_bridge.sv
src/pod_row.sv
dv/tb_pod_row.sv

//--- src/host_bridge.sv
module host_bridge
  import noc_pkg::*;
  import mc_pkg::*;
#(
  parameter int num_tiles_x_p = 4
) (
  input  logic clk_i
  ,input  logic rst_i

  // host request
  ,input  logic req_v_i
  ,output logic req_ready_o
  ,input  mc_op_e req_op_i
  ,input  logic [x_cord_width_gp-1:0] req_x_i
  ,input  logic [addr_width_gp-1:0] req_addr_i
  ,input  logic [data_width_gp-1:0] req_data_i

  // host response
  ,output logic resp_v_o
  ,input  logic resp_ready_i
  ,output logic [x_cord_width_gp-1:0] resp_x_o
  ,output mc_op_e resp_op_o
  ,output logic [addr_width_gp-1:0] resp_addr_o
  ,output logic [data_width_gp-1:0] resp_data_o

  // into the first router
  ,output logic net_v_o
  ,input  logic net_ready_i
  ,output mc_op_e net_op_o
  ,output logic [x_cord_width_gp-1:0] net_dst_x_o
  ,output logic [x_cord_width_gp-1:0] net_src_x_o
  ,output logic [addr_width_gp-1:0] net_addr_o
  ,output logic [data_width_gp-1:0] net_data_o

  // out of the first router
  ,input  logic net_v_i
  ,output logic net_ready_o
  ,input  mc_op_e net_op_i
  ,input  logic [x_cord_width_gp-1:0] net_src_x_i
  ,input  logic [addr_width_gp-1:0] net_addr_i
  ,input  logic [data_width_gp-1:0] net_data_i
);

  localparam logic [x_cord_width_gp-1:0] max_x_lp = x_cord_width_gp'(num_tiles_x_p);

  logic dst_ok;
  logic resp_v_q;
  logic resp_load;

  // bad coordinate: hold off the host, never inject
  assign dst_ok = (req_x_i != '0) && (req_x_i <= max_x_lp);
  assign req_ready_o = net_ready_i & dst_ok;
  assign net_v_o = req_v_i & dst_ok;
  assign net_op_o = req_op_i;
  assign net_dst_x_o = req_x_i;
  assign net_src_x_o = '0;
  assign net_addr_o = req_addr_i;
  assign net_data_o = req_data_i;

  // response slot refills in the cycle the host drains it
  assign net_ready_o = ~resp_v_q | resp_ready_i;
  assign resp_load = net_v_i & net_ready_o;
  assign resp_v_o = resp_v_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_v_q <= 1'b0;
    end else if (resp_load) begin
      resp_v_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_load) begin
      resp_x_o <= net_src_x_i;
      resp_op_o <= net_op_i;
      resp_addr_o <= net_addr_i;
      resp_data_o <= net_data_i;
    end
  end

endmodule

//--- src/mc_pkg.sv
package mc_pkg;

  // scratchpad word address and data word
  localparam int addr_width_gp = 6;
  localparam int data_width_gp = 32;

  // packet opcode
  typedef enum logic [1:0] {
    op_store = 2'd0
    ,op_load = 2'd1
    // ack of a store or data of a load
    ,op_resp = 2'd2
  } mc_op_e;

endpackage

//--- src/mesh_router.sv
module mesh_router
  import noc_pkg::*;
  import mc_pkg::*;
#(
  parameter int my_x_p = 1
) (
  input  logic clk_i
  ,input  logic rst_i

  // incoming links
  ,input  logic [dir_p:dir_w] link_v_i
  ,output logic [dir_p:dir_w] link_ready_o
  ,input  mc_op_e [dir_p:dir_w] link_op_i
  ,input  logic [dir_p:dir_w][x_cord_width_gp-1:0] link_dst_x_i
  ,input  logic [dir_p:dir_w][x_cord_width_gp-1:0] link_src_x_i
  ,input  logic [dir_p:dir_w][addr_width_gp-1:0] link_addr_i
  ,input  logic [dir_p:dir_w][data_width_gp-1:0] link_data_i

  // outgoing links
  ,output logic [dir_p:dir_w] link_v_o
  ,input  logic [dir_p:dir_w] link_ready_i
  ,output mc_op_e [dir_p:dir_w] link_op_o
  ,output logic [dir_p:dir_w][x_cord_width_gp-1:0] link_dst_x_o
  ,output logic [dir_p:dir_w][x_cord_width_gp-1:0] link_src_x_o
  ,output logic [dir_p:dir_w][addr_width_gp-1:0] link_addr_o
  ,output logic [dir_p:dir_w][data_width_gp-1:0] link_data_o
);

  localparam logic [x_cord_width_gp-1:0] my_x_lp = x_cord_width_gp'(my_x_p);

  // head of each input buffer
  logic [dir_p:dir_w] head_v;
  logic [dir_p:dir_w] head_taken;
  mc_op_e [dir_p:dir_w] head_op;
  logic [dir_p:dir_w][x_cord_width_gp-1:0] head_dst_x;
  logic [dir_p:dir_w][x_cord_width_gp-1:0] head_src_x;
  logic [dir_p:dir_w][addr_width_gp-1:0] head_addr;
  logic [dir_p:dir_w][data_width_gp-1:0] head_data;
  router_dir_e head_dir [num_dirs_gp];

  // out_req[o][i]: input i wants output o
  logic [num_dirs_gp-1:0] out_req [num_dirs_gp];
  logic [1:0] out_sel [num_dirs_gp];

  // first requester at or after ptr, wrapping
  function automatic logic [1:0] rr_pick(input logic [num_dirs_gp-1:0] req,
                                         input logic [1:0] ptr);
    logic [1:0] pick;
    int idx;
    pick = ptr;
    for (int k = num_dirs_gp - 1; k >= 0; k--) begin
      idx = (int'(ptr) + k) % num_dirs_gp;
      if (req[idx]) begin
        pick = 2'(idx);
      end
    end
    return pick;
  endfunction

  for (genvar i = 0; i < num_dirs_gp; i++) begin : in_buf
    mc_op_e op_q [2];
    logic [x_cord_width_gp-1:0] dst_x_q [2];
    logic [x_cord_width_gp-1:0] src_x_q [2];
    logic [addr_width_gp-1:0] addr_q [2];
    logic [data_width_gp-1:0] data_q [2];
    logic wr_ptr_q;
    logic rd_ptr_q;
    logic [1:0] count_q;
    logic enq;
    logic deq;

    assign link_ready_o[i] = (count_q != 2'd2);
    assign enq = link_v_i[i] & link_ready_o[i];
    assign deq = head_taken[i];

    assign head_v[i] = (count_q != 2'd0);
    assign head_op[i] = op_q[rd_ptr_q];
    assign head_dst_x[i] = dst_x_q[rd_ptr_q];
    assign head_src_x[i] = src_x_q[rd_ptr_q];
    assign head_addr[i] = addr_q[rd_ptr_q];
    assign head_data[i] = data_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        wr_ptr_q <= 1'b0;
        rd_ptr_q <= 1'b0;
        count_q <= 2'd0;
      end else begin
        if (enq) begin
          wr_ptr_q <= ~wr_ptr_q;
        end
        if (deq) begin
          rd_ptr_q <= ~rd_ptr_q;
        end
        count_q <= count_q + 2'(enq) - 2'(deq);
      end
    end

    always_ff @(posedge clk_i) begin
      if (enq) begin
        op_q[wr_ptr_q] <= link_op_i[i];
        dst_x_q[wr_ptr_q] <= link_dst_x_i[i];
        src_x_q[wr_ptr_q] <= link_src_x_i[i];
        addr_q[wr_ptr_q] <= link_addr_i[i];
        data_q[wr_ptr_q] <= link_data_i[i];
      end
    end

    // dimension order along x only
    always_comb begin
      if (head_dst_x[i] > my_x_lp) begin
        head_dir[i] = dir_e;
      end else if (head_dst_x[i] < my_x_lp) begin
        head_dir[i] = dir_w;
      end else begin
        head_dir[i] = dir_p;
      end
    end
  end

  always_comb begin
    for (int o = 0; o < num_dirs_gp; o++) begin
      for (int i = 0; i < num_dirs_gp; i++) begin
        out_req[o][i] = head_v[i] && (head_dir[i] == o);
      end
    end
  end

  for (genvar o = 0; o < num_dirs_gp; o++) begin : out_arb
    logic [1:0] rr_q;

    assign out_sel[o] = rr_pick(out_req[o], rr_q);
    assign link_v_o[o] = |out_req[o];
    assign link_op_o[o] = head_op[out_sel[o]];
    assign link_dst_x_o[o] = head_dst_x[out_sel[o]];
    assign link_src_x_o[o] = head_src_x[out_sel[o]];
    assign link_addr_o[o] = head_addr[out_sel[o]];
    assign link_data_o[o] = head_data[out_sel[o]];

    // winner drops to lowest priority
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        rr_q <= 2'd0;
      end else if (link_v_o[o] && link_ready_i[o]) begin
        rr_q <= (out_sel[o] == 2'(num_dirs_gp - 1)) ? 2'd0 : out_sel[o] + 2'd1;
      end
    end
  end

  // each input asks for one output only
  always_comb begin
    head_taken = '0;
    for (int o = 0; o < num_dirs_gp; o++) begin
      if (link_v_o[o] && link_ready_i[o]) begin
        head_taken[out_sel[o]] = 1'b1;
      end
    end
  end

endmodule

//--- src/noc_pkg.sv
package noc_pkg;

  // x coordinate along the row, the host sits at 0
  localparam int x_cord_width_gp = 4;

  // west, east and local
  localparam int num_dirs_gp = 3;

  // router port index, also the bit position in every per-direction vector
  typedef enum logic [1:0] {
    dir_w = 2'd0
    ,dir_e = 2'd1
    ,dir_p = 2'd2
  } router_dir_e;

endpackage

//--- src/pod_row.sv
module pod_row
  import noc_pkg::*;
  import mc_pkg::*;
#(
  parameter int num_tiles_x_p = 4
) (
  input  logic clk_i
  ,input  logic rst_i

  ,input  logic req_v_i
  ,output logic req_ready_o
  ,input  mc_op_e req_op_i
  ,input  logic [x_cord_width_gp-1:0] req_x_i
  ,input  logic [addr_width_gp-1:0] req_addr_i
  ,input  logic [data_width_gp-1:0] req_data_i

  ,output logic resp_v_o
  ,input  logic resp_ready_i
  ,output logic [x_cord_width_gp-1:0] resp_x_o
  ,output mc_op_e resp_op_o
  ,output logic [addr_width_gp-1:0] resp_addr_o
  ,output logic [data_width_gp-1:0] resp_data_o
);

  // node 0 is the bridge, node last_lp the tied-off east edge
  localparam int last_lp = num_tiles_x_p + 1;

  // per node: what it sends out and whether it can take a packet in
  logic [dir_p:dir_w] tx_v [0:last_lp];
  mc_op_e [dir_p:dir_w] tx_op [0:last_lp];
  logic [dir_p:dir_w][x_cord_width_gp-1:0] tx_dst_x [0:last_lp];
  logic [dir_p:dir_w][x_cord_width_gp-1:0] tx_src_x [0:last_lp];
  logic [dir_p:dir_w][addr_width_gp-1:0] tx_addr [0:last_lp];
  logic [dir_p:dir_w][data_width_gp-1:0] tx_data [0:last_lp];
  logic [dir_p:dir_w] rx_ready [0:last_lp];

  host_bridge #(
    .num_tiles_x_p(num_tiles_x_p)
  ) bridge (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.req_v_i(req_v_i)
    ,.req_ready_o(req_ready_o)
    ,.req_op_i(req_op_i)
    ,.req_x_i(req_x_i)
    ,.req_addr_i(req_addr_i)
    ,.req_data_i(req_data_i)
    ,.resp_v_o(resp_v_o)
    ,.resp_ready_i(resp_ready_i)
    ,.resp_x_o(resp_x_o)
    ,.resp_op_o(resp_op_o)
    ,.resp_addr_o(resp_addr_o)
    ,.resp_data_o(resp_data_o)
    ,.net_v_o(tx_v[0][dir_e])
    ,.net_ready_i(rx_ready[1][dir_w])
    ,.net_op_o(tx_op[0][dir_e])
    ,.net_dst_x_o(tx_dst_x[0][dir_e])
    ,.net_src_x_o(tx_src_x[0][dir_e])
    ,.net_addr_o(tx_addr[0][dir_e])
    ,.net_data_o(tx_data[0][dir_e])
    ,.net_v_i(tx_v[1][dir_w])
    ,.net_ready_o(rx_ready[0][dir_e])
    ,.net_op_i(tx_op[1][dir_w])
    ,.net_src_x_i(tx_src_x[1][dir_w])
    ,.net_addr_i(tx_addr[1][dir_w])
    ,.net_data_i(tx_data[1][dir_w])
  );

  // east edge: nothing comes in, anything going out is sunk
  assign tx_v[last_lp][dir_w] = 1'b0;
  assign tx_op[last_lp][dir_w] = op_store;
  assign tx_dst_x[last_lp][dir_w] = '0;
  assign tx_src_x[last_lp][dir_w] = '0;
  assign tx_addr[last_lp][dir_w] = '0;
  assign tx_data[last_lp][dir_w] = '0;
  assign rx_ready[last_lp][dir_w] = 1'b1;

  for (genvar k = 1; k <= num_tiles_x_p; k++) begin : tile
    logic ep_req_ready;
    logic ep_v;
    mc_op_e ep_op;
    logic [x_cord_width_gp-1:0] ep_dst_x;
    logic [x_cord_width_gp-1:0] ep_src_x;
    logic [addr_width_gp-1:0] ep_addr;
    logic [data_width_gp-1:0] ep_data;

    // inputs ordered {local, east neighbour, west neighbour}
    mesh_router #(
      .my_x_p(k)
    ) router (
      .clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.link_v_i({ep_v, tx_v[k+1][dir_w], tx_v[k-1][dir_e]})
      ,.link_ready_o(rx_ready[k])
      ,.link_op_i('{ep_op, tx_op[k+1][dir_w], tx_op[k-1][dir_e]})
      ,.link_dst_x_i({ep_dst_x, tx_dst_x[k+1][dir_w], tx_dst_x[k-1][dir_e]})
      ,.link_src_x_i({ep_src_x, tx_src_x[k+1][dir_w], tx_src_x[k-1][dir_e]})
      ,.link_addr_i({ep_addr, tx_addr[k+1][dir_w], tx_addr[k-1][dir_e]})
      ,.link_data_i({ep_data, tx_data[k+1][dir_w], tx_data[k-1][dir_e]})
      ,.link_v_o(tx_v[k])
      ,.link_ready_i({ep_req_ready, rx_ready[k+1][dir_w], rx_ready[k-1][dir_e]})
      ,.link_op_o(tx_op[k])
      ,.link_dst_x_o(tx_dst_x[k])
      ,.link_src_x_o(tx_src_x[k])
      ,.link_addr_o(tx_addr[k])
      ,.link_data_o(tx_data[k])
    );

    tile_endpoint #(
      .my_x_p(k)
    ) endpoint (
      .clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.req_v_i(tx_v[k][dir_p])
      ,.req_ready_o(ep_req_ready)
      ,.req_op_i(tx_op[k][dir_p])
      ,.req_src_x_i(tx_src_x[k][dir_p])
      ,.req_addr_i(tx_addr[k][dir_p])
      ,.req_data_i(tx_data[k][dir_p])
      ,.resp_v_o(ep_v)
      ,.resp_ready_i(rx_ready[k][dir_p])
      ,.resp_op_o(ep_op)
      ,.resp_dst_x_o(ep_dst_x)
      ,.resp_src_x_o(ep_src_x)
      ,.resp_addr_o(ep_addr)
      ,.resp_data_o(ep_data)
    );
  end

endmodule

//--- src/tile_endpoint.sv
module tile_endpoint
  import noc_pkg::*;
  import mc_pkg::*;
#(
  parameter int my_x_p = 1
) (
  input  logic clk_i
  ,input  logic rst_i

  // request from the local router port
  ,input  logic req_v_i
  ,output logic req_ready_o
  ,input  mc_op_e req_op_i
  ,input  logic [x_cord_width_gp-1:0] req_src_x_i
  ,input  logic [addr_width_gp-1:0] req_addr_i
  ,input  logic [data_width_gp-1:0] req_data_i

  // response back into the router
  ,output logic resp_v_o
  ,input  logic resp_ready_i
  ,output mc_op_e resp_op_o
  ,output logic [x_cord_width_gp-1:0] resp_dst_x_o
  ,output logic [x_cord_width_gp-1:0] resp_src_x_o
  ,output logic [addr_width_gp-1:0] resp_addr_o
  ,output logic [data_width_gp-1:0] resp_data_o
);

  localparam int mem_words_lp = 1 << addr_width_gp;

  logic [data_width_gp-1:0] mem_q [mem_words_lp];
  logic pending_q;
  logic accept;

  // one request in flight, no new one until the response leaves
  assign req_ready_o = ~pending_q;
  assign accept = req_v_i & ~pending_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= 1'b0;
    end else if (accept) begin
      pending_q <= 1'b1;
    end else if (resp_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_dst_x_o <= req_src_x_i;
      resp_addr_o <= req_addr_i;
      if (req_op_i == op_store) begin
        mem_q[req_addr_i] <= req_data_i;
        // store ack echoes the written word
        resp_data_o <= req_data_i;
      end else begin
        resp_data_o <= mem_q[req_addr_i];
      end
    end
  end

  assign resp_v_o = pending_q;
  assign resp_op_o = op_resp;
  assign resp_src_x_o = x_cord_width_gp'(my_x_p);

endmodule
